//--- list.f
src/emib_pkg.sv
src/od_decode.sv
src/mm_write.sv
src/mm_read.sv
src/common_loader.sv
src/ram_arbiter.sv
src/emib_ram.sv
src/emib_top.sv
tests/tb_emib.sv

//--- src/common_loader.sv
// Tracks the configured flag and loads node identity fields from RAM after the flash image load
module common_loader
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_flash_wr_en,    // Snooped flash writes
	input  emib_pkg::addr_t i_flash_waddr,
	input  emib_pkg::word_t i_flash_data,
	input  logic            i_read_flash_done,
	input  logic            i_gnt,
	input  emib_pkg::word_t i_ram_q,
	output logic            o_req,
	output emib_pkg::addr_t o_addr,
	output logic [31:0]     o_local_node_ip,
	output logic [47:0]     o_local_node_mac,
	output emib_pkg::word_t o_device_type,
	output emib_pkg::word_t o_device_state,
	output logic            o_common_rd_done
);

	import emib_pkg::*;

	localparam int SR_W = IDENT_LEN * WORD_W; // Whole identity block

	ld_state_e        state;
	len_t             cnt;                    // Words fetched so far
	logic             config_valid;           // Sticky until reset
	logic [SR_W-1:0]  ident_sr;               // MS word ends up on top

	assign o_req = (state == LD_FETCH);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			config_valid <= 1'b0;
		else if (i_flash_wr_en && i_flash_waddr == CFG_STATUS_ADDR &&
			i_flash_data == CFG_DONE_CODE)
			config_valid <= 1'b1;
	end

	// Identity words shift in as they arrive
	always_ff @(posedge i_clk)
	begin
		if (state == LD_WAIT)
			ident_sr <= {ident_sr[SR_W-WORD_W-1:0], i_ram_q};
	end

	//**************************************************************************
	// Load sequence
	//**************************************************************************
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state            <= LD_IDLE;
			cnt              <= '0;
			o_addr           <= '0;
			o_local_node_ip  <= '0;
			o_local_node_mac <= '0;
			o_device_type    <= '0;
			o_device_state   <= '0;
			o_common_rd_done <= 1'b0;
		end
		else
		begin
			o_common_rd_done <= 1'b0;
			case (state)
				LD_IDLE:
				begin
					if (i_read_flash_done && config_valid)  // Unconfigured image ignored
					begin
						o_addr <= IDENT_BASE;
						cnt    <= '0;
						state  <= LD_FETCH;
					end
				end
				LD_FETCH:
					if (i_gnt)
						state <= LD_WAIT;
				LD_WAIT:
				begin
					cnt    <= cnt + 1'b1;
					o_addr <= o_addr + 1'b1;
					state  <= (cnt + 1'b1 == IDENT_LEN) ? LD_STORE : LD_FETCH;
				end
				LD_STORE:
				begin
					o_local_node_ip  <= ident_sr[111:80];  // Words 0 and 1
					o_local_node_mac <= ident_sr[79:32];   // Words 2 to 4
					o_device_type    <= ident_sr[31:16];
					o_device_state   <= ident_sr[15:0];
					o_common_rd_done <= 1'b1;
					state            <= LD_IDLE;
				end
				default:
					state <= LD_IDLE;
			endcase
		end
	end

endmodule

//--- src/emib_pkg.sv
// Shared widths, RAM map, object codes and engine states; imported by every EMIB module
package emib_pkg;

	//**************************************************************************
	// Widths and basic types
	//**************************************************************************
	localparam int ADDR_W    = 6;                 // RAM address bits
	localparam int RAM_DEPTH = 64;                // Parameter words
	localparam int WORD_W    = 16;                // RAM word bits

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] len_t;             // Object length in words

	//**************************************************************************
	// Object dictionary
	//**************************************************************************
	typedef enum logic [15:0]
	{
		OBJ_DEVICE = 16'd1,
		OBJ_TIMING = 16'd2
	} obj_id_e;

	// Device object sub-indices
	localparam logic [15:0] SUB_NODE_IP     = 16'd1;
	localparam logic [15:0] SUB_NODE_MAC    = 16'd2;
	localparam logic [15:0] SUB_DEV_TYPE    = 16'd3;
	localparam logic [15:0] SUB_DEV_STATE   = 16'd4;

	// Timing object sub-indices
	localparam logic [15:0] SUB_MACRO_CYCLE = 16'd1;
	localparam logic [15:0] SUB_SEND_TIME   = 16'd2;
	localparam logic [15:0] SUB_CFG_STATUS  = 16'd14;

	// Field placement, MS word first
	localparam addr_t NODE_IP_ADDR      = 6'd0;
	localparam len_t  NODE_IP_LEN       = 6'd2;
	localparam addr_t NODE_MAC_ADDR     = 6'd2;
	localparam len_t  NODE_MAC_LEN      = 6'd3;
	localparam addr_t DEV_TYPE_ADDR     = 6'd5;
	localparam len_t  DEV_TYPE_LEN      = 6'd1;
	localparam addr_t DEV_STATE_ADDR    = 6'd6;
	localparam len_t  DEV_STATE_LEN     = 6'd1;
	localparam addr_t MACRO_CYCLE_ADDR  = 6'd8;
	localparam len_t  MACRO_CYCLE_LEN   = 6'd2;
	localparam addr_t SEND_TIME_ADDR    = 6'd10;
	localparam len_t  SEND_TIME_LEN     = 6'd2;
	localparam addr_t CFG_STATUS_ADDR   = 6'd52;
	localparam len_t  CFG_STATUS_LEN    = 6'd1;

	localparam word_t CFG_DONE_CODE     = 16'd2;  // Flash image marked configured
	localparam addr_t IDENT_BASE        = 6'd0;   // Node identity block start
	localparam len_t  IDENT_LEN         = 6'd7;   // IP, MAC, type, state

	//**************************************************************************
	// Engine states
	//**************************************************************************
	typedef enum logic [0:0] {WR_IDLE, WR_DATA} wr_state_e;
	typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_WAIT, RD_HOLD} rd_state_e;
	typedef enum logic [1:0] {LD_IDLE, LD_FETCH, LD_WAIT, LD_STORE} ld_state_e;

endpackage

//--- src/emib_ram.sv
// Parameter RAM with one write port and one registered read port, mapped onto block RAM
module emib_ram
(
	input  logic            i_clk,
	input  logic            i_we,
	input  emib_pkg::addr_t i_waddr,
	input  emib_pkg::word_t i_wdata,
	input  logic            i_re,
	input  emib_pkg::addr_t i_raddr,
	output emib_pkg::word_t o_q               // Valid one cycle after i_re
);

	import emib_pkg::*;

	word_t mem [RAM_DEPTH];

	always_ff @(posedge i_clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
		if (i_re)
			o_q <= mem[i_raddr];              // Old data on a same-address write
	end

endmodule

//--- src/emib_top.sv
// EMIB top level joining the decoder, engines, arbiter and RAM to the host and flash pins
module emib_top
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  emib_pkg::obj_id_e i_dobjid,
	input  logic [15:0]       i_subidx,
	input  logic              i_wr_en,
	input  emib_pkg::word_t   i_mm_data,
	input  logic              i_rd_en,
	input  logic              i_rd_rsp_en,
	output emib_pkg::addr_t   o_base_addr,
	output emib_pkg::word_t   o_mm_data,
	output logic              o_rd_valid,
	output emib_pkg::len_t    o_mm_data_len,
	output logic              o_write_done,
	output logic              o_write_error,
	output logic              o_read_done,
	output logic              o_read_error,
	input  logic              i_flash_wr_en,
	input  emib_pkg::addr_t   i_flash_waddr,
	input  emib_pkg::word_t   i_flash_data,
	input  logic              i_flash_rd_en,
	input  emib_pkg::addr_t   i_flash_raddr,
	output emib_pkg::word_t   o_flash_data,
	input  logic              i_read_flash_done,
	output logic [31:0]       o_local_node_ip,
	output logic [47:0]       o_local_node_mac,
	output emib_pkg::word_t   o_device_type,
	output emib_pkg::word_t   o_device_state,
	output logic              o_common_rd_done
);

	import emib_pkg::*;

	len_t  od_len;
	logic  od_error;
	logic  wr_req, wr_gnt, rd_req, rd_gnt, ld_req, ld_gnt;
	addr_t wr_addr, rd_addr, ld_addr;
	word_t wr_data;
	logic  ram_we, ram_re;
	addr_t ram_waddr, ram_raddr;
	word_t ram_wdata, ram_q;

	//**************************************************************************
	// Decoder and peers
	//**************************************************************************
	od_decode u_od (.i_dobjid(i_dobjid), .i_subidx(i_subidx), .o_base(o_base_addr),
		.o_len(od_len), .o_error(od_error));

	mm_write u_wr (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wr_en(i_wr_en), .i_mm_data(i_mm_data),
		.i_base(o_base_addr), .i_len(od_len), .i_od_error(od_error), .i_gnt(wr_gnt),
		.o_req(wr_req), .o_addr(wr_addr), .o_data(wr_data), .o_write_done(o_write_done),
		.o_write_error(o_write_error));

	mm_read u_rd (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_rd_en(i_rd_en),
		.i_rd_rsp_en(i_rd_rsp_en), .i_base(o_base_addr), .i_len(od_len),
		.i_od_error(od_error), .i_gnt(rd_gnt), .i_ram_q(ram_q), .o_req(rd_req),
		.o_addr(rd_addr), .o_mm_data(o_mm_data), .o_rd_valid(o_rd_valid),
		.o_mm_data_len(o_mm_data_len), .o_read_done(o_read_done),
		.o_read_error(o_read_error));

	common_loader u_ld (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_flash_wr_en(i_flash_wr_en),
		.i_flash_waddr(i_flash_waddr), .i_flash_data(i_flash_data),
		.i_read_flash_done(i_read_flash_done), .i_gnt(ld_gnt), .i_ram_q(ram_q),
		.o_req(ld_req), .o_addr(ld_addr), .o_local_node_ip(o_local_node_ip),
		.o_local_node_mac(o_local_node_mac), .o_device_type(o_device_type),
		.o_device_state(o_device_state), .o_common_rd_done(o_common_rd_done));

	//**************************************************************************
	// Shared RAM behind the arbiter
	//**************************************************************************
	ram_arbiter u_arb (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_flash_wr_en(i_flash_wr_en),
		.i_flash_waddr(i_flash_waddr), .i_flash_data(i_flash_data),
		.i_flash_rd_en(i_flash_rd_en), .i_flash_raddr(i_flash_raddr), .i_wr_req(wr_req),
		.i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_rd_req(rd_req), .i_rd_addr(rd_addr),
		.i_ld_req(ld_req), .i_ld_addr(ld_addr), .o_wr_gnt(wr_gnt), .o_rd_gnt(rd_gnt),
		.o_ld_gnt(ld_gnt), .o_ram_we(ram_we), .o_ram_waddr(ram_waddr),
		.o_ram_wdata(ram_wdata), .o_ram_re(ram_re), .o_ram_raddr(ram_raddr),
		.i_ram_q(ram_q), .o_flash_data(o_flash_data));

	emib_ram u_ram (.i_clk(i_clk), .i_we(ram_we), .i_waddr(ram_waddr), .i_wdata(ram_wdata),
		.i_re(ram_re), .i_raddr(ram_raddr), .o_q(ram_q));

endmodule

//--- src/mm_read.sv
// MM read engine that fetches an object word by word and holds each for the host acknowledge
module mm_read
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_rd_en,          // Starts one object read
	input  logic            i_rd_rsp_en,      // Host takes the held word
	input  emib_pkg::addr_t i_base,
	input  emib_pkg::len_t  i_len,
	input  logic            i_od_error,
	input  logic            i_gnt,
	input  emib_pkg::word_t i_ram_q,
	output logic            o_req,
	output emib_pkg::addr_t o_addr,
	output emib_pkg::word_t o_mm_data,
	output logic            o_rd_valid,       // Word present on o_mm_data
	output emib_pkg::len_t  o_mm_data_len,
	output logic            o_read_done,
	output logic            o_read_error
);

	import emib_pkg::*;

	rd_state_e state;
	len_t      cnt;                           // Words already acknowledged

	assign o_req = (state == RD_FETCH);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state         <= RD_IDLE;
			cnt           <= '0;
			o_addr        <= '0;
			o_mm_data     <= '0;
			o_rd_valid    <= 1'b0;
			o_mm_data_len <= '0;
			o_read_done   <= 1'b0;
			o_read_error  <= 1'b0;
		end
		else
		begin
			o_read_done  <= 1'b0;
			o_read_error <= 1'b0;
			case (state)
				RD_IDLE:
				begin
					if (i_rd_en && i_od_error)
						o_read_error <= 1'b1;
					else if (i_rd_en)
					begin
						o_mm_data_len <= i_len;
						o_addr        <= i_base;
						cnt           <= '0;
						state         <= RD_FETCH;
					end
				end
				RD_FETCH:
					if (i_gnt)
						state <= RD_WAIT;     // RAM returns data next cycle
				RD_WAIT:
				begin
					o_mm_data  <= i_ram_q;
					o_rd_valid <= 1'b1;
					state      <= RD_HOLD;
				end
				RD_HOLD:
				begin
					if (i_rd_rsp_en)          // Stall here until the host acknowledges
					begin
						o_rd_valid <= 1'b0;
						cnt        <= cnt + 1'b1;
						o_addr     <= o_addr + 1'b1;
						if (cnt + 1'b1 == o_mm_data_len)
						begin
							o_read_done <= 1'b1;
							state       <= RD_IDLE;
						end
						else
							state <= RD_FETCH;
					end
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

endmodule

//--- src/mm_write.sv
// MM write engine that takes host words of one object and requests RAM writes word by word
module mm_write
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_wr_en,          // One strobe per host word
	input  emib_pkg::word_t i_mm_data,
	input  emib_pkg::addr_t i_base,
	input  emib_pkg::len_t  i_len,
	input  logic            i_od_error,
	input  logic            i_gnt,
	output logic            o_req,            // Held until granted
	output emib_pkg::addr_t o_addr,
	output emib_pkg::word_t o_data,
	output logic            o_write_done,
	output logic            o_write_error
);

	import emib_pkg::*;

	wr_state_e state;
	len_t      cnt;                           // Words already granted

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state         <= WR_IDLE;
			cnt           <= '0;
			o_req         <= 1'b0;
			o_addr        <= '0;
			o_data        <= '0;
			o_write_done  <= 1'b0;
			o_write_error <= 1'b0;
		end
		else
		begin
			o_write_done  <= 1'b0;            // Pulses last one cycle
			o_write_error <= 1'b0;
			if (i_wr_en && !o_req)
				o_data <= i_mm_data;          // Strobes during a pending request dropped
			case (state)
				WR_IDLE:
				begin
					if (i_wr_en && i_od_error)
						o_write_error <= 1'b1;
					else if (i_wr_en)
					begin
						o_addr <= i_base;
						cnt    <= '0;
						o_req  <= 1'b1;
						state  <= WR_DATA;
					end
				end
				WR_DATA:
				begin
					if (o_req && i_gnt)
					begin
						o_req  <= 1'b0;
						o_addr <= o_addr + 1'b1;  // Next word of the field
						cnt    <= cnt + 1'b1;
						if (cnt + 1'b1 == i_len)
						begin
							o_write_done <= 1'b1;
							state        <= WR_IDLE;
						end
					end
					else if (i_wr_en && !o_req)
						o_req <= 1'b1;
				end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

endmodule

//--- src/od_decode.sv
// Combinational object-dictionary lookup giving base address, length and error to the engines
module od_decode
(
	input  emib_pkg::obj_id_e i_dobjid,       // Held by host for the access
	input  logic [15:0]       i_subidx,
	output emib_pkg::addr_t   o_base,         // First word of the field
	output emib_pkg::len_t    o_len,          // Field length in words
	output logic              o_error         // Unknown object or sub-index
);

	import emib_pkg::*;

	always_comb
	begin
		o_base  = '0;                         // Zero when nothing matches
		o_len   = '0;
		o_error = 1'b0;
		case (i_dobjid)
			OBJ_DEVICE:
			begin
				case (i_subidx)
					SUB_NODE_IP:     {o_base, o_len} = {NODE_IP_ADDR, NODE_IP_LEN};
					SUB_NODE_MAC:    {o_base, o_len} = {NODE_MAC_ADDR, NODE_MAC_LEN};
					SUB_DEV_TYPE:    {o_base, o_len} = {DEV_TYPE_ADDR, DEV_TYPE_LEN};
					SUB_DEV_STATE:   {o_base, o_len} = {DEV_STATE_ADDR, DEV_STATE_LEN};
					default:         o_error = 1'b1;
				endcase
			end
			OBJ_TIMING:
			begin
				case (i_subidx)
					SUB_MACRO_CYCLE: {o_base, o_len} = {MACRO_CYCLE_ADDR, MACRO_CYCLE_LEN};
					SUB_SEND_TIME:   {o_base, o_len} = {SEND_TIME_ADDR, SEND_TIME_LEN};
					SUB_CFG_STATUS:  {o_base, o_len} = {CFG_STATUS_ADDR, CFG_STATUS_LEN};
					default:         o_error = 1'b1;
				endcase
			end
			default:
				o_error = 1'b1;               // Object not in the dictionary
		endcase
	end

endmodule

//--- src/ram_arbiter.sv
// Fixed-priority arbiter putting the flash port and the three engines onto the parameter RAM
module ram_arbiter
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_flash_wr_en,    // Top priority, never stalled
	input  emib_pkg::addr_t i_flash_waddr,
	input  emib_pkg::word_t i_flash_data,
	input  logic            i_flash_rd_en,
	input  emib_pkg::addr_t i_flash_raddr,
	input  logic            i_wr_req,         // MM write engine
	input  emib_pkg::addr_t i_wr_addr,
	input  emib_pkg::word_t i_wr_data,
	input  logic            i_rd_req,         // MM read engine
	input  emib_pkg::addr_t i_rd_addr,
	input  logic            i_ld_req,         // Common loader
	input  emib_pkg::addr_t i_ld_addr,
	output logic            o_wr_gnt,
	output logic            o_rd_gnt,
	output logic            o_ld_gnt,
	output logic            o_ram_we,
	output emib_pkg::addr_t o_ram_waddr,
	output emib_pkg::word_t o_ram_wdata,
	output logic            o_ram_re,
	output emib_pkg::addr_t o_ram_raddr,
	input  emib_pkg::word_t i_ram_q,
	output emib_pkg::word_t o_flash_data      // Two cycles behind the strobe
);

	logic flash_busy;                         // Flash owns this cycle
	logic flash_rd_gnt;                       // Read dropped under a flash write
	logic flash_rd_d;                         // ram_q belongs to the flash next cycle

	assign flash_busy   = i_flash_wr_en | i_flash_rd_en;
	assign flash_rd_gnt = i_flash_rd_en & ~i_flash_wr_en;

	// Priority chain, same-cycle grants
	assign o_wr_gnt = i_wr_req & ~flash_busy;
	assign o_rd_gnt = i_rd_req & ~flash_busy & ~i_wr_req;
	assign o_ld_gnt = i_ld_req & ~flash_busy & ~i_wr_req & ~i_rd_req;

	assign o_ram_we    = i_flash_wr_en | o_wr_gnt;
	assign o_ram_waddr = i_flash_wr_en ? i_flash_waddr : i_wr_addr;
	assign o_ram_wdata = i_flash_wr_en ? i_flash_data : i_wr_data;
	assign o_ram_re    = flash_rd_gnt | o_rd_gnt | o_ld_gnt;
	assign o_ram_raddr = flash_rd_gnt ? i_flash_raddr :
		o_rd_gnt ? i_rd_addr : i_ld_addr;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			flash_rd_d   <= 1'b0;
			o_flash_data <= '0;
		end
		else
		begin
			flash_rd_d <= flash_rd_gnt;
			if (flash_rd_d)
				o_flash_data <= i_ram_q;      // Held until the next flash read
		end
	end

endmodule

//--- tests/tb_emib.sv
// Directed testbench for emib_top covering flash, MM write/read, errors, loader and contention
module tb_emib;

	timeunit 1ns;
	timeprecision 100ps;

	import emib_pkg::*;

	localparam int TMO = 200;                 // Cycles per wait loop

	logic        i_clk, i_rst_n;
	obj_id_e     i_dobjid;
	logic [15:0] i_subidx;
	logic        i_wr_en, i_rd_en, i_rd_rsp_en;
	word_t       i_mm_data;
	addr_t       o_base_addr;
	word_t       o_mm_data;
	logic        o_rd_valid;
	len_t        o_mm_data_len;
	logic        o_write_done, o_write_error, o_read_done, o_read_error;
	logic        i_flash_wr_en, i_flash_rd_en;
	addr_t       i_flash_waddr, i_flash_raddr;
	word_t       i_flash_data, o_flash_data;
	logic        i_read_flash_done, o_common_rd_done;
	logic [31:0] o_local_node_ip;
	logic [47:0] o_local_node_mac;
	word_t       o_device_type, o_device_state;

	word_t       model [64];                  // Expected RAM contents
	logic [31:0] lfsr_state = 32'h05e5_64f3;
	int          n_mismatch, n_fail;
	int          n_wr_done, n_rd_done, n_wr_err, n_rd_err, n_ld_done;

	emib_top dut0 (.*);

	always #4 i_clk = ~i_clk;                 // 8 ns period

	// Pulse counters, sampled on the falling edge
	always @(negedge i_clk)
	begin
		if (o_write_done)     n_wr_done++;
		if (o_read_done)      n_rd_done++;
		if (o_write_error)    n_wr_err++;
		if (o_read_error)     n_rd_err++;
		if (o_common_rd_done) n_ld_done++;
	end

	//**************************************************************************
	// Random source and compare tasks
	//**************************************************************************
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Taps 32,30,26,25
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};     // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			n_mismatch++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
		begin
			n_mismatch++;
			$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_len(input string name, input len_t exp, input len_t act);
		if (act !== exp)
		begin
			n_mismatch++;
			$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			n_mismatch++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	function automatic int pulse_count(input int kind);
		case (kind)
			0:       return n_wr_err;
			1:       return n_rd_err;
			default: return n_ld_done;
		endcase
	endfunction

	// Waits for a counted pulse; returns quietly if none is expected
	task automatic wait_pulse(input int kind, input int start, input bit expect_it,
		input string what);
		int t;
		t = 0;
		while (pulse_count(kind) == start && t < TMO)
		begin
			@(negedge i_clk);
			t++;
		end
		if (expect_it && t >= TMO)
		begin
			n_fail++;
			$display("Timeout at %0t ns: no %s pulse came", $time, what);
		end
		else if (!expect_it && t < TMO)
		begin
			n_fail++;
			$display("Unexpected %s pulse at %0t ns", what, $time);
		end
	endtask

	//**************************************************************************
	// Bus tasks, entered and left on a falling edge
	//**************************************************************************
	task automatic flash_write(input addr_t a, input word_t d);
		i_flash_wr_en = 1'b1;
		i_flash_waddr = a;
		i_flash_data  = d;
		model[a]      = d;
		@(negedge i_clk);
		i_flash_wr_en = 1'b0;
	endtask

	task automatic flash_read_check(input addr_t a);
		i_flash_rd_en = 1'b1;
		i_flash_raddr = a;
		@(negedge i_clk);
		i_flash_rd_en = 1'b0;
		@(negedge i_clk);                     // Fixed two-cycle latency
		check_word($sformatf("o_flash_data[%0d]", a), model[a], o_flash_data);
	endtask

	task automatic readback_all();
		for (int a = 0; a < 64; a++)
			flash_read_check(addr_t'(a));
	endtask

	task automatic mm_write_obj(input addr_t base, input len_t len);
		int    t;
		int    done0;
		word_t w;
		done0 = n_wr_done;
		for (int i = 0; i < len; i++)
		begin
			w = word_t'(rand_bits(16));
			i_wr_en   = 1'b1;
			i_mm_data = w;
			model[base + i] = w;
			@(negedge i_clk);
			i_wr_en = 1'b0;
			t = 0;
			while (dut0.wr_req && t < TMO)    // Next word only after the grant
			begin
				@(negedge i_clk);
				t++;
			end
			if (t >= TMO)
			begin
				n_fail++;
				$display("Timeout at %0t ns: MM write word %0d never granted", $time, i);
			end
		end
		repeat (2) @(negedge i_clk);
		check_word("o_write_done count", word_t'(done0 + 1), word_t'(n_wr_done));
	endtask

	task automatic mm_read_obj(input addr_t base, input len_t len);
		int t;
		int gap;
		int done0;
		done0 = n_rd_done;
		i_rd_en = 1'b1;
		@(negedge i_clk);
		i_rd_en = 1'b0;
		check_len("o_mm_data_len", len, o_mm_data_len);
		for (int i = 0; i < len; i++)
		begin
			t = 0;
			while (!o_rd_valid && t < TMO)
			begin
				@(negedge i_clk);
				t++;
			end
			if (t >= TMO)
			begin
				n_fail++;
				$display("Timeout at %0t ns: MM read word %0d never arrived", $time, i);
			end
			check_word($sformatf("o_mm_data[%0d]", base + i), model[base + i], o_mm_data);
			gap = int'(rand_bits(2));         // Host back-pressure
			repeat (gap)
			begin
				@(negedge i_clk);
				check_bit("o_rd_valid", 1'b1, o_rd_valid);
			end
			check_word("o_read_done count", word_t'(done0), word_t'(n_rd_done));
			i_rd_rsp_en = 1'b1;
			@(negedge i_clk);
			i_rd_rsp_en = 1'b0;
		end
		repeat (2) @(negedge i_clk);
		check_word("o_read_done count", word_t'(done0 + 1), word_t'(n_rd_done));
		check_bit("o_rd_valid", 1'b0, o_rd_valid);
	endtask

	// Dictionary entries as (object, sub-index, base, length)
	task automatic get_object(input int idx, output obj_id_e obj, output logic [15:0] sub,
		output addr_t base, output len_t len);
		obj = (idx < 4) ? OBJ_DEVICE : OBJ_TIMING;
		case (idx)
			0:       {sub, base, len} = {16'd1, 6'd0, 6'd2};
			1:       {sub, base, len} = {16'd2, 6'd2, 6'd3};
			2:       {sub, base, len} = {16'd3, 6'd5, 6'd1};
			3:       {sub, base, len} = {16'd4, 6'd6, 6'd1};
			4:       {sub, base, len} = {16'd1, 6'd8, 6'd2};
			5:       {sub, base, len} = {16'd2, 6'd10, 6'd2};
			default: {sub, base, len} = {16'd14, 6'd52, 6'd1};
		endcase
	endtask

	//**************************************************************************
	// Directed tests
	//**************************************************************************
	task automatic test_flash_load();
		word_t d;
		for (int a = 0; a < 64; a++)
		begin
			d = word_t'(rand_bits(16));
			if (a == 52 && d == 16'd2)
				d = 16'd3;                    // Keep the image unconfigured
			flash_write(addr_t'(a), d);
		end
		readback_all();
	endtask

	task automatic test_objects();
		obj_id_e     obj;
		logic [15:0] sub;
		addr_t       base;
		len_t        len;
		for (int k = 0; k < 7; k++)
		begin
			get_object(k, obj, sub, base, len);
			i_dobjid = obj;
			i_subidx = sub;
			@(negedge i_clk);
			check_addr("o_base_addr", base, o_base_addr);
			mm_write_obj(base, len);
			mm_read_obj(base, len);
		end
	endtask

	task automatic test_unknown();
		int e0;
		e0 = n_wr_err;
		i_dobjid  = obj_id_e'(16'd7);        // Object not in the dictionary
		i_subidx  = 16'd1;
		i_wr_en   = 1'b1;
		i_mm_data = word_t'(rand_bits(16));
		@(negedge i_clk);
		i_wr_en = 1'b0;
		wait_pulse(0, e0, 1'b1, "o_write_error");
		e0 = n_rd_err;
		i_dobjid = OBJ_DEVICE;
		i_subidx = 16'd9;                     // Bad sub-index
		i_rd_en  = 1'b1;
		@(negedge i_clk);
		i_rd_en = 1'b0;
		wait_pulse(1, e0, 1'b1, "o_read_error");
		check_bit("o_rd_valid", 1'b0, o_rd_valid);
		readback_all();
	endtask

	task automatic test_contention();
		word_t fd [20:39];
		for (int a = 20; a < 40; a++)
			fd[a] = word_t'(rand_bits(16));
		i_dobjid = OBJ_TIMING;
		i_subidx = 16'd2;                     // Send time, words 10 and 11
		@(negedge i_clk);
		fork
			mm_write_obj(6'd10, 6'd2);
			for (int a = 20; a < 32; a++)
				flash_write(addr_t'(a), fd[a]);
		join
		fork
			mm_read_obj(6'd10, 6'd2);
			for (int a = 32; a < 40; a++)
			begin
				flash_write(addr_t'(a), fd[a]);
				flash_read_check(addr_t'(a));
			end
		join
		readback_all();
	endtask

	task automatic test_config_gate();
		int d0;
		d0 = n_ld_done;
		i_read_flash_done = 1'b1;
		@(negedge i_clk);
		i_read_flash_done = 1'b0;
		wait_pulse(2, d0, 1'b0, "o_common_rd_done");
		check_word("o_local_node_ip[31:16]", 16'h0, o_local_node_ip[31:16]);
		check_word("o_local_node_ip[15:0]", 16'h0, o_local_node_ip[15:0]);
		check_word("o_local_node_mac[47:32]", 16'h0, o_local_node_mac[47:32]);
		check_word("o_local_node_mac[31:16]", 16'h0, o_local_node_mac[31:16]);
		check_word("o_local_node_mac[15:0]", 16'h0, o_local_node_mac[15:0]);
		check_word("o_device_type", 16'h0, o_device_type);
		check_word("o_device_state", 16'h0, o_device_state);
		flash_write(6'd52, 16'd2);            // Mark the image configured
		d0 = n_ld_done;
		i_read_flash_done = 1'b1;
		@(negedge i_clk);
		i_read_flash_done = 1'b0;
		wait_pulse(2, d0, 1'b1, "o_common_rd_done");
		check_word("o_local_node_ip[31:16]", model[0], o_local_node_ip[31:16]);
		check_word("o_local_node_ip[15:0]", model[1], o_local_node_ip[15:0]);
		check_word("o_local_node_mac[47:32]", model[2], o_local_node_mac[47:32]);
		check_word("o_local_node_mac[31:16]", model[3], o_local_node_mac[31:16]);
		check_word("o_local_node_mac[15:0]", model[4], o_local_node_mac[15:0]);
		check_word("o_device_type", model[5], o_device_type);
		check_word("o_device_state", model[6], o_device_state);
	endtask

	initial
	begin
		i_clk             = 1'b0;
		i_rst_n           = 1'b0;
		i_dobjid          = OBJ_DEVICE;
		i_subidx          = '0;
		i_wr_en           = 1'b0;
		i_mm_data         = '0;
		i_rd_en           = 1'b0;
		i_rd_rsp_en       = 1'b0;
		i_flash_wr_en     = 1'b0;
		i_flash_waddr     = '0;
		i_flash_data      = '0;
		i_flash_rd_en     = 1'b0;
		i_flash_raddr     = '0;
		i_read_flash_done = 1'b0;
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		check_bit("o_rd_valid", 1'b0, o_rd_valid);
		check_word("o_flash_data", 16'h0, o_flash_data);
		test_flash_load();
		test_objects();
		test_unknown();
		test_contention();
		test_config_gate();
		repeat (4) @(negedge i_clk);
		$display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
		if (n_mismatch == 0 && n_fail == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
